/* hdl/udp_pkg.sv */
package udp_pkg;

    // header as seen from this end of the link
    typedef struct packed {
        logic [31:0] peer_ip;
        logic [15:0] peer_port;
        logic [15:0] local_port;
    } udp_hdr_t;

    // single-word packets only
    typedef struct packed {
        udp_hdr_t    hdr;
        logic [63:0] data;
    } udp_pkt_t;

    localparam int NUM_HANDLERS = 3;
    localparam int IDX_W = $clog2(NUM_HANDLERS);

    typedef logic [IDX_W-1:0] handler_idx_t;

    // 'Ta', 'Tn', 'Tc'
    localparam logic [15:0] PORT_TA = 16'd21601;
    localparam logic [15:0] PORT_TN = 16'd21614;
    localparam logic [15:0] PORT_TC = 16'd21603;

    // switch and mux both follow this order
    localparam int IDX_TA = 0;
    localparam int IDX_TN = 1;
    localparam int IDX_TC = 2;

    // index 0 sits in the low bits
    localparam logic [NUM_HANDLERS*16-1:0] HANDLER_PORTS = {
        PORT_TC,
        PORT_TN,
        PORT_TA
    };

endpackage

/* hdl/event_pkg.sv */
package event_pkg;

    // command code lives in the top byte of the payload
    localparam int CMD_HI = 63;
    localparam int CMD_LO = 56;

    localparam logic [7:0] CMD_OPEN  = 8'h01;
    localparam logic [7:0] CMD_CLOSE = 8'h02;

    // control reply reports the open flag here
    localparam int OPEN_BIT = 0;

    // payload bits each acknowledge flavour keeps
    localparam logic [63:0] ACK_CHECK  = 64'h800000FF_FFF00000;
    localparam logic [63:0] NACK_CHECK = 64'h000000FF_FFFFFFFF;

    typedef struct packed {
        logic        open;
        logic [31:0] ip;
        logic [15:0] port;
    } event_t;

endpackage

/* hdl/udp_port_switch.sv */
module udp_port_switch (
    input  logic                               clk,
    input  logic                               rst_i,

    input  udp_pkg::udp_pkt_t                  s_pkt_i,
    input  logic                               s_valid_i,
    output logic                               s_ready_o,

    output udp_pkg::udp_pkt_t                  h_pkt_o,
    output logic [udp_pkg::NUM_HANDLERS-1:0]   h_valid_o,
    input  logic [udp_pkg::NUM_HANDLERS-1:0]   h_ready_i
);
    import udp_pkg::*;

    udp_pkt_t     slot_pkt_q;
    handler_idx_t slot_idx_q;
    logic         slot_valid_q;

    logic         match_hit;
    handler_idx_t match_idx;
    logic         slot_take;
    logic         s_accept;

    // exact match on the destination (local) port
    always_comb begin
        match_hit = 1'b0;
        match_idx = '0;
        for (int i = 0; i < NUM_HANDLERS; i++) begin
            if (s_pkt_i.hdr.local_port == HANDLER_PORTS[16*i +: 16]) begin
                match_hit = 1'b1;
                match_idx = handler_idx_t'(i);
            end
        end
    end

    assign slot_take = slot_valid_q && h_ready_i[slot_idx_q];
    // slot free now or emptying this cycle
    assign s_ready_o = !slot_valid_q || slot_take;
    assign s_accept  = s_valid_i && s_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            slot_valid_q <= 1'b0;
            slot_idx_q   <= '0;
        end else if (s_accept) begin
            // unmatched ports are swallowed and the slot stays empty
            slot_valid_q <= match_hit;
            slot_idx_q   <= match_idx;
        end else if (slot_take) begin
            slot_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (s_accept) begin
            slot_pkt_q <= s_pkt_i;
        end
    end

    assign h_pkt_o = slot_pkt_q;

    // only the target handler sees valid
    always_comb begin
        for (int i = 0; i < NUM_HANDLERS; i++) begin
            h_valid_o[i] = slot_valid_q && (slot_idx_q == handler_idx_t'(i));
        end
    end

endmodule

/* hdl/acknack_port.sv */
module acknack_port #(
    parameter logic [63:0] CHECK_BITS = event_pkg::ACK_CHECK
) (
    input  logic                clk,
    input  logic                rst_i,

    input  udp_pkg::udp_pkt_t   req_pkt_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,

    input  event_pkg::event_t   event_i,

    output udp_pkg::udp_pkt_t   rsp_pkt_o,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,

    output logic [63:0]         an_data_o,
    output logic                an_valid_o,
    input  logic                an_ready_i
);
    import udp_pkg::*;
    import event_pkg::*;

    udp_pkt_t    rsp_q;
    logic        rsp_valid_q;
    logic [63:0] an_data_q;
    logic        an_valid_q;

    logic [63:0] kept_word;
    logic        req_accept;
    event_t      ev;

    assign ev        = event_i;
    assign kept_word = req_pkt_i.data & CHECK_BITS;

    // both output slots must be free before taking a new request
    assign req_ready_o = !rsp_valid_q && !an_valid_q;
    assign req_accept  = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            rsp_valid_q <= 1'b0;
            an_valid_q  <= 1'b0;
        end else if (req_accept) begin
            rsp_valid_q <= 1'b1;
            // side word only goes out with an open event
            an_valid_q  <= ev.open;
        end else begin
            if (rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
            if (an_ready_i) begin
                an_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            // local port is overwritten downstream by the mux
            rsp_q.hdr  <= req_pkt_i.hdr;
            rsp_q.data <= ev.open ? kept_word : 64'd0;
            an_data_q  <= kept_word;
        end
    end

    assign rsp_pkt_o   = rsp_q;
    assign rsp_valid_o = rsp_valid_q;
    assign an_data_o   = an_data_q;
    assign an_valid_o  = an_valid_q;

endmodule

/* hdl/event_ctrl_port.sv */
module event_ctrl_port (
    input  logic                clk,
    input  logic                rst_i,

    input  udp_pkg::udp_pkt_t   req_pkt_i,
    input  logic                req_valid_i,
    output logic                req_ready_o,

    output udp_pkg::udp_pkt_t   rsp_pkt_o,
    output logic                rsp_valid_o,
    input  logic                rsp_ready_i,

    output event_pkg::event_t   event_o
);
    import udp_pkg::*;
    import event_pkg::*;

    event_t     event_q;
    udp_pkt_t   rsp_q;
    logic       rsp_valid_q;

    logic [7:0] cmd;
    logic       open_next;
    logic       req_accept;

    assign cmd = req_pkt_i.data[CMD_HI:CMD_LO];

    // open flag as it will be after this command
    always_comb begin
        open_next = event_q.open;
        if (cmd == CMD_OPEN) begin
            open_next = 1'b1;
        end else if (cmd == CMD_CLOSE) begin
            open_next = 1'b0;
        end
    end

    assign req_ready_o = !rsp_valid_q;
    assign req_accept  = req_valid_i && req_ready_o;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            event_q     <= '0;
            rsp_valid_q <= 1'b0;
        end else begin
            if (req_accept) begin
                rsp_valid_q  <= 1'b1;
                event_q.open <= open_next;
                // open also latches where events get sent
                if (cmd == CMD_OPEN) begin
                    event_q.ip   <= req_pkt_i.hdr.peer_ip;
                    event_q.port <= req_pkt_i.data[15:0];
                end
            end else if (rsp_ready_i) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_accept) begin
            rsp_q.hdr                <= req_pkt_i.hdr;
            rsp_q.data               <= '0;
            rsp_q.data[CMD_HI:CMD_LO] <= cmd;
            rsp_q.data[OPEN_BIT]     <= open_next;
        end
    end

    assign rsp_pkt_o   = rsp_q;
    assign rsp_valid_o = rsp_valid_q;
    assign event_o     = event_q;

endmodule

/* hdl/udp_port_mux.sv */
module udp_port_mux (
    input  logic                                              clk,
    input  logic                                              rst_i,

    input  udp_pkg::udp_pkt_t [udp_pkg::NUM_HANDLERS-1:0]     h_pkt_i,
    input  logic [udp_pkg::NUM_HANDLERS-1:0]                  h_valid_i,
    output logic [udp_pkg::NUM_HANDLERS-1:0]                  h_ready_o,

    output udp_pkg::udp_pkt_t                                 m_pkt_o,
    output logic                                              m_valid_o,
    input  logic                                              m_ready_i
);
    import udp_pkg::*;

    udp_pkt_t     out_pkt_q;
    logic         out_valid_q;
    handler_idx_t last_q;

    logic         load_ok;
    logic         grant_hit;
    handler_idx_t grant_idx;
    udp_pkt_t     win_pkt;

    // output register free, or being drained this cycle
    assign load_ok = !out_valid_q || m_ready_i;

    // round-robin search starting just after the last winner
    always_comb begin
        int cand;
        grant_hit = 1'b0;
        grant_idx = last_q;
        for (int k = 1; k <= NUM_HANDLERS; k++) begin
            cand = (int'(last_q) + k) % NUM_HANDLERS;
            if (!grant_hit && h_valid_i[cand]) begin
                grant_hit = 1'b1;
                grant_idx = handler_idx_t'(cand);
            end
        end
    end

    // stamp the winner's own port as source
    always_comb begin
        win_pkt                = h_pkt_i[grant_idx];
        win_pkt.hdr.local_port = HANDLER_PORTS[16*grant_idx +: 16];
    end

    always_comb begin
        for (int i = 0; i < NUM_HANDLERS; i++) begin
            h_ready_o[i] = load_ok && grant_hit && (grant_idx == handler_idx_t'(i));
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            out_valid_q <= 1'b0;
            // first search then begins at index 0
            last_q      <= handler_idx_t'(NUM_HANDLERS - 1);
        end else if (load_ok) begin
            out_valid_q <= grant_hit;
            if (grant_hit) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_ok && grant_hit) begin
            out_pkt_q <= win_pkt;
        end
    end

    assign m_pkt_o   = out_pkt_q;
    assign m_valid_o = out_valid_q;

endmodule

/* hdl/turf_udp_fabric.sv */
module turf_udp_fabric (
    input  logic                clk,
    input  logic                rst_i,

    // inbound UDP
    input  udp_pkg::udp_pkt_t   s_pkt_i,
    input  logic                s_valid_i,
    output logic                s_ready_o,

    // outbound UDP
    output udp_pkg::udp_pkt_t   m_pkt_o,
    output logic                m_valid_o,
    input  logic                m_ready_i,

    output logic [63:0]         ack_data_o,
    output logic                ack_valid_o,
    input  logic                ack_ready_i,

    output logic [63:0]         nack_data_o,
    output logic                nack_valid_o,
    input  logic                nack_ready_i,

    output logic                event_open_o
);
    import udp_pkg::*;
    import event_pkg::*;

    // switch to handlers over one shared packet bus
    udp_pkt_t                    req_pkt;
    logic [NUM_HANDLERS-1:0]     req_valid;
    logic [NUM_HANDLERS-1:0]     req_ready;

    // handlers to mux
    udp_pkt_t [NUM_HANDLERS-1:0] rsp_pkt;
    logic [NUM_HANDLERS-1:0]     rsp_valid;
    logic [NUM_HANDLERS-1:0]     rsp_ready;

    event_t                      event_state;

    assign event_open_o = event_state.open;

    udp_port_switch u_switch (
        .clk         (clk),
        .rst_i       (rst_i),
        .s_pkt_i     (s_pkt_i),
        .s_valid_i   (s_valid_i),
        .s_ready_o   (s_ready_o),
        .h_pkt_o     (req_pkt),
        .h_valid_o   (req_valid),
        .h_ready_i   (req_ready)
    );

    // ack and nack differ only in which bits they keep
    acknack_port #(.CHECK_BITS(ACK_CHECK)) u_ackport (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_pkt_i   (req_pkt),
        .req_valid_i (req_valid[IDX_TA]),
        .req_ready_o (req_ready[IDX_TA]),
        .event_i     (event_state),
        .rsp_pkt_o   (rsp_pkt[IDX_TA]),
        .rsp_valid_o (rsp_valid[IDX_TA]),
        .rsp_ready_i (rsp_ready[IDX_TA]),
        .an_data_o   (ack_data_o),
        .an_valid_o  (ack_valid_o),
        .an_ready_i  (ack_ready_i)
    );

    acknack_port #(.CHECK_BITS(NACK_CHECK)) u_nackport (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_pkt_i   (req_pkt),
        .req_valid_i (req_valid[IDX_TN]),
        .req_ready_o (req_ready[IDX_TN]),
        .event_i     (event_state),
        .rsp_pkt_o   (rsp_pkt[IDX_TN]),
        .rsp_valid_o (rsp_valid[IDX_TN]),
        .rsp_ready_i (rsp_ready[IDX_TN]),
        .an_data_o   (nack_data_o),
        .an_valid_o  (nack_valid_o),
        .an_ready_i  (nack_ready_i)
    );

    event_ctrl_port u_ctrlport (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_pkt_i   (req_pkt),
        .req_valid_i (req_valid[IDX_TC]),
        .req_ready_o (req_ready[IDX_TC]),
        .rsp_pkt_o   (rsp_pkt[IDX_TC]),
        .rsp_valid_o (rsp_valid[IDX_TC]),
        .rsp_ready_i (rsp_ready[IDX_TC]),
        .event_o     (event_state)
    );

    udp_port_mux u_mux (
        .clk         (clk),
        .rst_i       (rst_i),
        .h_pkt_i     (rsp_pkt),
        .h_valid_i   (rsp_valid),
        .h_ready_o   (rsp_ready),
        .m_pkt_o     (m_pkt_o),
        .m_valid_o   (m_valid_o),
        .m_ready_i   (m_ready_i)
    );

endmodule

/* verification/turf_udp_fabric_chk.sv */
module turf_udp_fabric_chk (
    input  logic              clk,
    input  logic              rst_i,
    input  udp_pkg::udp_pkt_t m_pkt_o,
    input  logic              m_valid_o,
    input  logic              m_ready_i,
    input  logic [63:0]       ack_data_o,
    input  logic              ack_valid_o,
    input  logic              ack_ready_i,
    input  logic [63:0]       nack_data_o,
    input  logic              nack_valid_o,
    input  logic              nack_ready_i,
    input  logic              event_open_o
);
    int fails = 0;

    // every output stream and the event flag start quiet
    reset_quiet: assert property (@(posedge clk)
        rst_i |=> !m_valid_o && !ack_valid_o && !nack_valid_o && !event_open_o)
        else begin
            fails++;
            $error("valid or event_open_o high right after reset");
        end

    m_hold: assert property (@(posedge clk) disable iff (rst_i)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_pkt_o))
        else begin
            fails++;
            $error("m_valid_o dropped or m_pkt_o changed while stalled");
        end

    ack_hold: assert property (@(posedge clk) disable iff (rst_i)
        ack_valid_o && !ack_ready_i |=> ack_valid_o && $stable(ack_data_o))
        else begin
            fails++;
            $error("ack_valid_o dropped or ack_data_o changed while stalled");
        end

    nack_hold: assert property (@(posedge clk) disable iff (rst_i)
        nack_valid_o && !nack_ready_i |=> nack_valid_o && $stable(nack_data_o))
        else begin
            fails++;
            $error("nack_valid_o dropped or nack_data_o changed while stalled");
        end

endmodule

/* verification/turf_udp_fabric_tb.sv */
module turf_udp_fabric_tb;
    import udp_pkg::*;
    import event_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_PKTS   = 400;

    logic        clk;
    logic        rst_i;
    udp_pkt_t    s_pkt_i;
    logic        s_valid_i;
    logic        s_ready_o;
    udp_pkt_t    m_pkt_o;
    logic        m_valid_o;
    logic        m_ready_i;
    logic [63:0] ack_data_o;
    logic        ack_valid_o;
    logic        ack_ready_i;
    logic [63:0] nack_data_o;
    logic        nack_valid_o;
    logic        nack_ready_i;
    logic        event_open_o;

    int          seed = 32'hcf76852b;
    int          sent = 0;
    int          pkt_errs = 0;
    int          word_errs = 0;
    int          flag_errs = 0;
    int          other_errs = 0;
    logic        s_fire = 1'b0;
    logic        model_open = 1'b0;

    // expected traffic with one queue per handler and per side stream
    udp_pkt_t    ta_q[$];
    udp_pkt_t    tn_q[$];
    udp_pkt_t    tc_q[$];
    logic [63:0] ack_q[$];
    logic [63:0] nack_q[$];

    turf_udp_fabric turf_udp_fabric_inst (.*);

    bind turf_udp_fabric turf_udp_fabric_chk u_chk (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_pkt(input string name, input udp_pkt_t got, input udp_pkt_t exp);
        if (got !== exp) begin
            pkt_errs++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            word_errs++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errs++;
            $display("[ERROR] %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic all_drained();
        return ta_q.size() == 0 && tn_q.size() == 0 && tc_q.size() == 0
            && ack_q.size() == 0 && nack_q.size() == 0;
    endfunction

    // expected reply and side word from the event state at switch accept
    task automatic model_request(input udp_pkt_t req);
        udp_pkt_t   exp;
        logic [7:0] cmd;
        exp = req;
        cmd = req.data[63:56];
        case (req.hdr.local_port)
            PORT_TA: begin
                exp.data = model_open ? (req.data & ACK_CHECK) : 64'd0;
                if (model_open)
                    ack_q.push_back(req.data & ACK_CHECK);
                ta_q.push_back(exp);
            end
            PORT_TN: begin
                exp.data = model_open ? (req.data & NACK_CHECK) : 64'd0;
                if (model_open)
                    nack_q.push_back(req.data & NACK_CHECK);
                tn_q.push_back(exp);
            end
            PORT_TC: begin
                if (cmd == CMD_OPEN)
                    model_open = 1'b1;
                else if (cmd == CMD_CLOSE)
                    model_open = 1'b0;
                exp.data = {cmd, 55'd0, model_open};
                tc_q.push_back(exp);
            end
            default: ;
        endcase
    endtask

    // order is only kept per handler, so look up by source port
    task automatic take_reply(input udp_pkt_t got);
        udp_pkt_t exp;
        logic     found;
        found = 1'b0;
        if (got.hdr.local_port == PORT_TA && ta_q.size() > 0) begin
            exp = ta_q.pop_front();
            found = 1'b1;
        end else if (got.hdr.local_port == PORT_TN && tn_q.size() > 0) begin
            exp = tn_q.pop_front();
            found = 1'b1;
        end else if (got.hdr.local_port == PORT_TC && tc_q.size() > 0) begin
            exp = tc_q.pop_front();
            found = 1'b1;
        end
        if (found) begin
            check_pkt("m_pkt_o", got, exp);
        end else begin
            other_errs++;
            $display("reply from local port %0d arrived with no request pending",
                     got.hdr.local_port);
        end
    endtask

    task automatic make_pkt(output udp_pkt_t pkt);
        int kind;
        int pick;
        kind = {$random(seed)} % 8;
        pick = {$random(seed)} % 8;
        pkt.hdr.peer_ip   = $random(seed);
        pkt.hdr.peer_port = 16'($random(seed));
        pkt.data          = {$random(seed), $random(seed)};
        // open/close only once no acknowledge is in flight
        if ((kind == 5 || kind == 6) && (ta_q.size() > 0 || tn_q.size() > 0))
            kind = 7;
        case (kind)
            0, 1, 2: pkt.hdr.local_port = PORT_TA;
            3, 4:    pkt.hdr.local_port = PORT_TN;
            5, 6: begin
                pkt.hdr.local_port = PORT_TC;
                if (pick < 4)
                    pkt.data[63:56] = CMD_OPEN;
                else if (pick < 7)
                    pkt.data[63:56] = CMD_CLOSE;
                else
                    pkt.data[63:56] = 8'($random(seed));
            end
            default: begin
                pkt.hdr.local_port = 16'($random(seed));
                if (pkt.hdr.local_port == PORT_TA || pkt.hdr.local_port == PORT_TN
                        || pkt.hdr.local_port == PORT_TC)
                    pkt.hdr.local_port = 16'd21600;
            end
        endcase
    endtask

    // outputs settle by the falling edge and transfer at the next rise
    always @(negedge clk) begin
        if (rst_i) begin
            s_fire = 1'b0;
        end else begin
            s_fire = s_valid_i && s_ready_o;
            if (tc_q.size() == 0)
                check_flag("event_open_o", event_open_o, model_open);
            if (m_valid_o && m_ready_i)
                take_reply(m_pkt_o);
            if (ack_valid_o && ack_ready_i) begin
                if (ack_q.size() > 0) begin
                    check_word("ack_data_o", ack_data_o, ack_q.pop_front());
                end else begin
                    other_errs++;
                    $display("ack word seen with none expected");
                end
            end
            if (nack_valid_o && nack_ready_i) begin
                if (nack_q.size() > 0) begin
                    check_word("nack_data_o", nack_data_o, nack_q.pop_front());
                end else begin
                    other_errs++;
                    $display("nack word seen with none expected");
                end
            end
            if (s_fire)
                model_request(s_pkt_i);
        end
    end

    initial begin
        logic     done;
        udp_pkt_t pkt;
        rst_i        = 1'b1;
        s_pkt_i      = '0;
        s_valid_i    = 1'b0;
        m_ready_i    = 1'b0;
        ack_ready_i  = 1'b0;
        nack_ready_i = 1'b0;
        done         = 1'b0;
        repeat (16) @(posedge clk);
        rst_i <= 1'b0;
        while (!done) begin
            @(posedge clk);
            done = sent == NUM_PKTS && (!s_valid_i || s_fire) && all_drained();
            m_ready_i    <= ({$random(seed)} % 4) != 0;
            ack_ready_i  <= ({$random(seed)} % 4) != 0;
            nack_ready_i <= ({$random(seed)} % 4) != 0;
            if (!s_valid_i || s_fire) begin
                if (sent < NUM_PKTS && ({$random(seed)} % 3) != 0) begin
                    make_pkt(pkt);
                    s_pkt_i   <= pkt;
                    s_valid_i <= 1'b1;
                    sent++;
                end else begin
                    s_valid_i <= 1'b0;
                end
            end
        end
        // quiet tail where nothing more may come out
        m_ready_i    <= 1'b1;
        ack_ready_i  <= 1'b1;
        nack_ready_i <= 1'b1;
        repeat (20) @(posedge clk);
        $display("errors: packet %0d, word %0d, flag %0d, other %0d, assertion %0d",
                 pkt_errs, word_errs, flag_errs, other_errs, turf_udp_fabric_inst.u_chk.fails);
        if (pkt_errs + word_errs + flag_errs + other_errs
                + turf_udp_fabric_inst.u_chk.fails == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        #(NUM_PKTS * 40 * CLK_PERIOD);
        $display("timeout after %0d cycles with traffic still pending", NUM_PKTS * 40);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* turf_udp_fabric.f */
hdl/udp_pkg.sv
hdl/event_pkg.sv
hdl/udp_port_switch.sv
hdl/acknack_port.sv
hdl/event_ctrl_port.sv
hdl/udp_port_mux.sv
hdl/turf_udp_fabric.sv
verification/turf_udp_fabric_chk.sv
verification/turf_udp_fabric_tb.sv

/* Makefile */
TOP := turf_udp_fabric_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f turf_udp_fabric.f -o sim
	./obj_dir/sim +verilator+error+limit+100 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
